/* Makefile */
TOP := tbDatapath

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall +incdir+. datapathPkg.sv registerFile.sv \
		instrDecoder.sv operandStage.sv alu.sv statusFlags.sv datapathTop.sv \
		--top-module datapathTop

obj_dir/V$(TOP): datapath.f *.sv *.svh
	verilator --binary --timing --assert -f datapath.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* alu.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module alu
(
	input  datapathPkg::opcodeT    opcode,
	input  logic [`DATA_WIDTH-1:0] opA,
	input  logic [`DATA_WIDTH-1:0] opB,
	input  logic [`DATA_WIDTH-1:0] imm,
	input  logic                   carryIn,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   zero,
	output logic                   carry,
	output logic                   neg,
	output logic                   ovf
);

	import datapathPkg::*;

	localparam int MSB = `DATA_WIDTH - 1;

	logic                 addCarry;
	logic [`DATA_WIDTH:0] sum;
	logic [`DATA_WIDTH:0] diff;
	logic                 addOvf;
	logic                 subOvf;

	////////////////////////////////////////////////////////////////////////////
	// Adder and subtractor
	////////////////////////////////////////////////////////////////////////////

	// Only ADC pulls in the stored carry
	assign addCarry = (opcode == ADC) ? carryIn : 1'b0;

	// One extra bit holds carry out or borrow
	assign sum  = {1'b0, opA} + {1'b0, opB} + {{`DATA_WIDTH{1'b0}}, addCarry};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// Signed overflow on matching/opposing operand signs
	assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
	assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

	////////////////////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		result = '0;
		carry  = 1'b0;
		ovf    = 1'b0;
		case (opcode)
			ADD, ADC:
			begin
				result = sum[MSB:0];
				carry  = sum[`DATA_WIDTH];
				ovf    = addOvf;
			end
			// Carry is borrow, set when opA < opB unsigned
			SUB, CMP:
			begin
				result = diff[MSB:0];
				carry  = diff[`DATA_WIDTH];
				ovf    = subOvf;
			end
			AND:
				result = opA & opB;
			OR:
				result = opA | opB;
			XOR:
				result = opA ^ opB;
			// Single-bit shifts, carry takes the bit that falls off
			SHL:
			begin
				result = {opA[MSB-1:0], 1'b0};
				carry  = opA[MSB];
			end
			SHR:
			begin
				result = {1'b0, opA[MSB:1]};
				carry  = opA[0];
			end
			MOVI:
				result = imm;
			default:
				result = '0;
		endcase
	end

	// Zero and sign come straight off the result
	assign zero = (result == '0);
	assign neg  = result[MSB];

endmodule

/* datapath.f */
+incdir+.
datapathPkg.sv
registerFile.sv
instrDecoder.sv
operandStage.sv
alu.sv
statusFlags.sv
datapathTop.sv
tbDatapath.sv

/* datapathPkg.sv */
package datapathPkg;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	// Top nibble of the instruction word
	// Codes above MOVI are illegal and run as NOP
	typedef enum logic [3:0]
	{
		NOP  = 4'h0,
		ADD  = 4'h1,
		ADC  = 4'h2,
		SUB  = 4'h3,
		AND  = 4'h4,
		OR   = 4'h5,
		XOR  = 4'h6,
		SHL  = 4'h7,
		SHR  = 4'h8,
		CMP  = 4'h9,
		MOVI = 4'hA
	} opcodeT;

endpackage

/* datapathTop.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module datapathTop
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`INSTR_WIDTH-1:0]    instr,
	input  logic                       instrValid,
	output logic                       resultValid,
	output logic [`REG_ADDR_WIDTH-1:0] resultReg,
	output logic [`DATA_WIDTH-1:0]     resultData,
	output logic                       flagZero,
	output logic                       flagCarry,
	output logic                       flagNeg,
	output logic                       flagOvf
);

	import datapathPkg::*;

	// Issue stage
	opcodeT                     decOpcode;
	logic [`REG_ADDR_WIDTH-1:0] decRd;
	logic [`REG_ADDR_WIDTH-1:0] decRa;
	logic [`REG_ADDR_WIDTH-1:0] decRb;
	logic [`DATA_WIDTH-1:0]     decImm;
	logic                       decWritesReg;
	logic                       decSetsFlags;
	logic [`DATA_WIDTH-1:0]     readDataA;
	logic [`DATA_WIDTH-1:0]     readDataB;

	// Execute stage
	opcodeT                     exOpcode;
	logic [`REG_ADDR_WIDTH-1:0] exRd;
	logic [`DATA_WIDTH-1:0]     exImm;
	logic                       exWrite;
	logic                       exSetsFlags;
	logic [`DATA_WIDTH-1:0]     opA;
	logic [`DATA_WIDTH-1:0]     opB;
	logic [`DATA_WIDTH-1:0]     aluResult;
	logic                       aluZero;
	logic                       aluCarry;
	logic                       aluNeg;
	logic                       aluOvf;

	////////////////////////////////////////////////////////////////////////////
	// Issue
	////////////////////////////////////////////////////////////////////////////

	instrDecoder decoder
	(
		.instr     (instr),
		.opcode    (decOpcode),
		.rd        (decRd),
		.ra        (decRa),
		.rb        (decRb),
		.imm       (decImm),
		.writesReg (decWritesReg),
		.setsFlags (decSetsFlags)
	);

	// Written back from the execute stage
	registerFile regFile
	(
		.clk       (clk),
		.rstN      (rstN),
		.writeEn   (exWrite),
		.writeIdx  (exRd),
		.writeData (aluResult),
		.readIdxA  (decRa),
		.readIdxB  (decRb),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

	operandStage operands
	(
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.opcode      (decOpcode),
		.rd          (decRd),
		.ra          (decRa),
		.rb          (decRb),
		.imm         (decImm),
		.writesReg   (decWritesReg),
		.setsFlags   (decSetsFlags),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.aluResult   (aluResult),
		.exOpcode    (exOpcode),
		.exRd        (exRd),
		.exImm       (exImm),
		.exWrite     (exWrite),
		.exSetsFlags (exSetsFlags),
		.opA         (opA),
		.opB         (opB)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute and writeback
	////////////////////////////////////////////////////////////////////////////

	alu execAlu
	(
		.opcode  (exOpcode),
		.opA     (opA),
		.opB     (opB),
		.imm     (exImm),
		.carryIn (flagCarry),
		.result  (aluResult),
		.zero    (aluZero),
		.carry   (aluCarry),
		.neg     (aluNeg),
		.ovf     (aluOvf)
	);

	statusFlags flags
	(
		.clk       (clk),
		.rstN      (rstN),
		.update    (exSetsFlags),
		.zeroIn    (aluZero),
		.carryIn   (aluCarry),
		.negIn     (aluNeg),
		.ovfIn     (aluOvf),
		.flagZero  (flagZero),
		.flagCarry (flagCarry),
		.flagNeg   (flagNeg),
		.flagOvf   (flagOvf)
	);

	// Result port mirrors the register file write
	// Pulses one cycle per writing instruction, holds data between pulses
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			resultValid <= 1'b0;
			resultReg   <= '0;
			resultData  <= '0;
		end
		else
		begin
			resultValid <= exWrite;
			if (exWrite)
			begin
				resultReg  <= exRd;
				resultData <= aluResult;
			end
		end
	end

endmodule

/* datapath_defs.svh */
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// Datapath word width, registers and ALU alike
`define DATA_WIDTH 16

// Instruction word width
`define INSTR_WIDTH 16

// Register file geometry
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// MOVI immediate, low byte of the instruction word
`define IMM_WIDTH 8

`endif

/* instrDecoder.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module instrDecoder
(
	input  logic [`INSTR_WIDTH-1:0]    instr,
	output datapathPkg::opcodeT        opcode,
	output logic [`REG_ADDR_WIDTH-1:0] rd,
	output logic [`REG_ADDR_WIDTH-1:0] ra,
	output logic [`REG_ADDR_WIDTH-1:0] rb,
	output logic [`DATA_WIDTH-1:0]     imm,
	output logic                       writesReg,
	output logic                       setsFlags
);

	import datapathPkg::*;

	// Raw opcode nibble before legality check
	logic [3:0] opField;

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	assign opField = instr[15:12];
	assign rd      = instr[11:8];
	assign ra      = instr[7:4];
	assign rb      = instr[3:0];

	// Zero-extended MOVI immediate
	assign imm = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, instr[`IMM_WIDTH-1:0]};

	// Illegal codes fall through to NOP
	always_comb
	begin
		case (opField)
			ADD, ADC, SUB, AND, OR, XOR, SHL, SHR, CMP, MOVI:
				opcode = opcodeT'(opField);
			default:
				opcode = NOP;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Controls
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		writesReg = 1'b1;
		setsFlags = 1'b1;
		case (opcode)
			NOP:
			begin
				writesReg = 1'b0;
				setsFlags = 1'b0;
			end
			// Compare only touches the flags
			CMP:
				writesReg = 1'b0;
			MOVI:
				setsFlags = 1'b0;
			default:
			begin
				writesReg = 1'b1;
				setsFlags = 1'b1;
			end
		endcase
	end

endmodule

/* operandStage.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module operandStage
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       instrValid,
	input  datapathPkg::opcodeT        opcode,
	input  logic [`REG_ADDR_WIDTH-1:0] rd,
	input  logic [`REG_ADDR_WIDTH-1:0] ra,
	input  logic [`REG_ADDR_WIDTH-1:0] rb,
	input  logic [`DATA_WIDTH-1:0]     imm,
	input  logic                       writesReg,
	input  logic                       setsFlags,
	input  logic [`DATA_WIDTH-1:0]     readDataA,
	input  logic [`DATA_WIDTH-1:0]     readDataB,
	input  logic [`DATA_WIDTH-1:0]     aluResult,
	output datapathPkg::opcodeT        exOpcode,
	output logic [`REG_ADDR_WIDTH-1:0] exRd,
	output logic [`DATA_WIDTH-1:0]     exImm,
	output logic                       exWrite,
	output logic                       exSetsFlags,
	output logic [`DATA_WIDTH-1:0]     opA,
	output logic [`DATA_WIDTH-1:0]     opB
);

	import datapathPkg::*;

	logic                   hitA;
	logic                   hitB;
	logic [`DATA_WIDTH-1:0] fwdA;
	logic [`DATA_WIDTH-1:0] fwdB;

	////////////////////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////////////////////

	// Execute-stage result not yet in the register file
	assign hitA = exWrite && (exRd == ra);
	assign hitB = exWrite && (exRd == rb);

	assign fwdA = hitA ? aluResult : readDataA;
	assign fwdB = hitB ? aluResult : readDataB;

	////////////////////////////////////////////////////////////////////////////
	// Execute latch
	////////////////////////////////////////////////////////////////////////////

	// Control half; an empty slot becomes a NOP
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			exOpcode    <= NOP;
			exRd        <= '0;
			exWrite     <= 1'b0;
			exSetsFlags <= 1'b0;
		end
		else if (instrValid)
		begin
			exOpcode    <= opcode;
			exRd        <= rd;
			exWrite     <= writesReg;
			exSetsFlags <= setsFlags;
		end
		else
		begin
			exOpcode    <= NOP;
			exWrite     <= 1'b0;
			exSetsFlags <= 1'b0;
		end
	end

	// Operand and immediate words
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			opA   <= fwdA;
			opB   <= fwdB;
			exImm <= imm;
		end
	end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module registerFile
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       writeEn,
	input  logic [`REG_ADDR_WIDTH-1:0] writeIdx,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	input  logic [`REG_ADDR_WIDTH-1:0] readIdxA,
	input  logic [`REG_ADDR_WIDTH-1:0] readIdxB,
	output logic [`DATA_WIDTH-1:0]     readDataA,
	output logic [`DATA_WIDTH-1:0]     readDataB
);

	// Register array, all entries cleared on reset
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn)
		begin
			regs[writeIdx] <= writeData;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// Port A mux, feeds the A side of the ALU
	always_comb
	begin
		readDataA = regs[readIdxA];
	end

	// Port B mux, feeds the B side
	always_comb
	begin
		readDataB = regs[readIdxB];
	end

	// A write in this cycle is not visible here yet
	// operandStage forwards the in-flight result around it

endmodule

/* statusFlags.sv */
`timescale 1ns/1ps

module statusFlags
(
	input  logic clk,
	input  logic rstN,
	input  logic update,
	input  logic zeroIn,
	input  logic carryIn,
	input  logic negIn,
	input  logic ovfIn,
	output logic flagZero,
	output logic flagCarry,
	output logic flagNeg,
	output logic flagOvf
);

	////////////////////////////////////////////////////////////////////////////
	// Flag register
	////////////////////////////////////////////////////////////////////////////

	// Loaded at writeback of flag-setting ops only
	// flagCarry loops back to the ALU for ADC
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			flagZero  <= 1'b0;
			flagCarry <= 1'b0;
			flagNeg   <= 1'b0;
			flagOvf   <= 1'b0;
		end
		else if (update)
		begin
			flagZero  <= zeroIn;
			flagCarry <= carryIn;
			flagNeg   <= negIn;
			flagOvf   <= ovfIn;
		end
	end

endmodule

/* tbDatapath.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module tbDatapath;

	import datapathPkg::*;

	localparam int clkPeriod      = 8;
	localparam int resetCycles    = 10;
	localparam int directedCycles = 200;
	localparam int randomCount    = 4000;
	localparam int watchdogCycles = resetCycles + directedCycles + randomCount + 100;

	logic                       clk;
	logic                       rstN;
	logic [`INSTR_WIDTH-1:0]    instr;
	logic                       instrValid;
	logic                       resultValid;
	logic [`REG_ADDR_WIDTH-1:0] resultReg;
	logic [`DATA_WIDTH-1:0]     resultData;
	logic                       flagZero;
	logic                       flagCarry;
	logic                       flagNeg;
	logic                       flagOvf;

	// Architectural model state, updated in issue order
	logic [`DATA_WIDTH-1:0]     refRegs [`REG_COUNT];
	logic [3:0]                 refFlags;

	// Instruction sitting in execute, visible after the next edge
	logic                       stWrite;
	logic                       stFlags;
	logic [`REG_ADDR_WIDTH-1:0] stRd;
	logic [`DATA_WIDTH-1:0]     stData;
	logic [3:0]                 stFlagVals;

	// What the DUT outputs should show now
	logic                       expValid;
	logic [`REG_ADDR_WIDTH-1:0] expReg;
	logic [`DATA_WIDTH-1:0]     expData;
	logic [3:0]                 expFlags;
	int                         expWrites;
	int                         obsWrites;
	logic [31:0]                lfsrState;

	datapathTop dut
	(
		.clk         (clk),
		.rstN        (rstN),
		.instr       (instr),
		.instrValid  (instrValid),
		.resultValid (resultValid),
		.resultReg   (resultReg),
		.resultData  (resultData),
		.flagZero    (flagZero),
		.flagCarry   (flagCarry),
		.flagNeg     (flagNeg),
		.flagOvf     (flagOvf)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [15:0] takeBits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
			bits = {bits[14:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic logic [15:0] encode(input opcodeT op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
		return {op, rd, ra, rb};
	endfunction

	function automatic logic [15:0] encodeImm(input logic [3:0] rd, input logic [7:0] imm);
		return {MOVI, rd, imm};
	endfunction

	task automatic issue(input logic [15:0] word);
		@(negedge clk);
		instr = word;
		instrValid = 1'b1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			instrValid = 1'b0;
		end
	endtask

	task automatic reportMismatch(input string what, input logic [15:0] got,
		input logic [15:0] want);
		$display("Error: time %0d ns, %s is 0x%h, expected 0x%h", $time, what, got, want);
		$display("*** TEST FAILED ***");
		$fatal(1, "Mismatch on %s", what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Flags packed as {zero, carry, neg, ovf}
	task automatic modelIssue(input logic [15:0] word);
		logic [3:0]  op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [16:0] wide;
		logic        c;
		logic        v;
		int          sr;
		op = word[15:12];
		a  = refRegs[word[7:4]];
		b  = refRegs[word[3:0]];
		c  = 1'b0;
		v  = 1'b0;
		sr = 0;
		if (op > 4'hA)
			op = NOP;
		case (op)
			ADD, ADC:
			begin
				wide = {1'b0, a} + {1'b0, b} + {16'b0, (op == ADC) && refFlags[2]};
				r    = wide[15:0];
				c    = wide[16];
				sr   = int'($signed(a)) + int'($signed(b)) + ((op == ADC && refFlags[2]) ? 1 : 0);
				v    = (sr > 32767) || (sr < -32768);
			end
			SUB, CMP:
			begin
				r  = a - b;
				c  = (a < b);
				sr = int'($signed(a)) - int'($signed(b));
				v  = (sr > 32767) || (sr < -32768);
			end
			AND:  r = a & b;
			OR:   r = a | b;
			XOR:  r = a ^ b;
			SHL:
			begin
				r = {a[14:0], 1'b0};
				c = a[15];
			end
			SHR:
			begin
				r = {1'b0, a[15:1]};
				c = a[0];
			end
			MOVI: r = {8'h00, word[7:0]};
			default: r = '0;
		endcase
		stWrite    = (op != NOP) && (op != CMP);
		stFlags    = (op != NOP) && (op != MOVI);
		stRd       = word[11:8];
		stData     = r;
		stFlagVals = {(r == 16'h0000), c, r[15], v};
		if (stWrite)
			refRegs[stRd] = r;
		if (stFlags)
			refFlags = stFlagVals;
	endtask

	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				refRegs[i] = '0;
			refFlags  = '0;
			stWrite   = 1'b0;
			stFlags   = 1'b0;
			expValid  = 1'b0;
			expReg    = '0;
			expData   = '0;
			expFlags  = '0;
			expWrites = 0;
		end
		else
		begin
			// Writeback of the instruction issued one edge ago
			expValid = stWrite;
			if (stWrite)
			begin
				expReg  = stRd;
				expData = stData;
				expWrites++;
			end
			if (stFlags)
				expFlags = stFlagVals;
			stWrite = 1'b0;
			stFlags = 1'b0;
			if (instrValid)
				modelIssue(instr);
		end
	end

	always @(negedge clk)
	begin
		if (!rstN)
			obsWrites = 0;
		else if (resultValid)
			obsWrites++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks, sampled mid-cycle where outputs are settled
	////////////////////////////////////////////////////////////////////////////

	checkValid: assert property (@(negedge clk) disable iff (!rstN) resultValid == expValid)
		else reportMismatch("resultValid", {15'b0, resultValid}, {15'b0, expValid});
	checkReg: assert property (@(negedge clk) disable iff (!rstN) resultReg == expReg)
		else reportMismatch("resultReg", {12'b0, resultReg}, {12'b0, expReg});
	checkData: assert property (@(negedge clk) disable iff (!rstN) resultData == expData)
		else reportMismatch("resultData", resultData, expData);
	checkZero: assert property (@(negedge clk) disable iff (!rstN) flagZero == expFlags[3])
		else reportMismatch("flagZero", {15'b0, flagZero}, {15'b0, expFlags[3]});
	checkCarry: assert property (@(negedge clk) disable iff (!rstN) flagCarry == expFlags[2])
		else reportMismatch("flagCarry", {15'b0, flagCarry}, {15'b0, expFlags[2]});
	checkNeg: assert property (@(negedge clk) disable iff (!rstN) flagNeg == expFlags[1])
		else reportMismatch("flagNeg", {15'b0, flagNeg}, {15'b0, expFlags[1]});
	checkOvf: assert property (@(negedge clk) disable iff (!rstN) flagOvf == expFlags[0])
		else reportMismatch("flagOvf", {15'b0, flagOvf}, {15'b0, expFlags[0]});

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired before the test sequence finished");
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [15:0] word;
		logic [15:0] gate;
		clk        = 1'b0;
		rstN       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		lfsrState  = 32'h55cf;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Registers read back as zero after reset
		for (int i = 0; i < `REG_COUNT; i++)
			issue(encode(OR, 4'(i), 4'(i), 4'(i)));
		idle(3);

		// Immediates, then read back
		for (int i = 0; i < `REG_COUNT; i++)
			issue(encodeImm(4'(i), {4'(i), ~4'(i)}));
		for (int i = 0; i < `REG_COUNT; i++)
			issue(encode(OR, 4'(i), 4'(i), 4'(i)));
		idle(3);

		// Dependent chain
		issue(encodeImm(4'd1, 8'h35));
		issue(encode(ADD, 4'd2, 4'd1, 4'd1));
		issue(encode(SUB, 4'd3, 4'd2, 4'd1));
		issue(encode(XOR, 4'd4, 4'd3, 4'd2));
		issue(encode(ADD, 4'd4, 4'd4, 4'd4));
		issue(encode(SHL, 4'd5, 4'd4, 4'd0));
		issue(encode(AND, 4'd6, 4'd5, 4'd4));
		issue(encode(OR, 4'd6, 4'd1, 4'd6));
		idle(1);
		issue(encode(ADD, 4'd7, 4'd6, 4'd6));
		idle(3);

		// Arithmetic corners, 0x8000 built by shifting
		issue(encodeImm(4'd8, 8'h01));
		issue(encodeImm(4'd6, 8'h80));
		repeat (8) issue(encode(SHL, 4'd6, 4'd6, 4'd0));
		issue(encode(SUB, 4'd7, 4'd6, 4'd8));
		issue(encode(ADD, 4'd9, 4'd7, 4'd8));
		issue(encode(ADD, 4'd10, 4'd6, 4'd6));
		issue(encode(ADC, 4'd11, 4'd8, 4'd0));
		issue(encode(SUB, 4'd12, 4'd8, 4'd6));
		issue(encode(CMP, 4'd0, 4'd8, 4'd8));
		issue(encode(NOP, 4'd3, 4'd3, 4'd3));
		issue(encode(ADC, 4'd13, 4'd8, 4'd8));
		issue(encode(CMP, 4'd0, 4'd8, 4'd6));
		issue(encode(ADC, 4'd13, 4'd13, 4'd8));
		idle(3);

		// Shifts, logic ops and illegal codes
		issue(encode(SHL, 4'd1, 4'd6, 4'd0));
		issue(encode(SHR, 4'd2, 4'd8, 4'd0));
		issue(encode(SHR, 4'd3, 4'd6, 4'd0));
		issue(encode(AND, 4'd4, 4'd7, 4'd6));
		issue(encode(OR, 4'd4, 4'd7, 4'd6));
		issue(encode(XOR, 4'd5, 4'd4, 4'd4));
		issue(encode(ADD, 4'd10, 4'd6, 4'd6));
		issue({4'hB, 4'd3, 4'd1, 4'd2});
		issue({4'hF, 4'd4, 4'd4, 4'd4});
		issue(encode(ADC, 4'd14, 4'd0, 4'd0));
		idle(3);

		// Random traffic with occasional bubbles
		for (int n = 0; n < randomCount; n++)
		begin
			word = takeBits(16);
			gate = takeBits(3);
			@(negedge clk);
			instr = word;
			instrValid = (gate[2:0] != 3'b000);
		end
		idle(4);

		if (obsWrites == expWrites && expWrites > 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
		begin
			$display("Result pulse count %0d does not match the %0d writes expected",
				obsWrites, expWrites);
			$display("*** TEST FAILED ***");
			$fatal(1, "Result count mismatch");
		end
	end

endmodule
